/* logic/cpu_defines.svh */
// Pipeline CPU parameters and encodings
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath sizing
`define CPU_WORD_W      32
`define CPU_REG_AW      5
`define CPU_NREGS       32
`define CPU_PC_INIT     32'h0000_0000

// opcodes
`define CPU_OP_RTYPE    6'h00
`define CPU_OP_ADDIU    6'h09
`define CPU_OP_LW       6'h23
`define CPU_OP_SW       6'h2B
`define CPU_OP_BEQ      6'h04
`define CPU_OP_HALT     6'h3F

// R-type funct codes
`define CPU_FN_ADDU     6'h21
`define CPU_FN_SUBU     6'h23
`define CPU_FN_AND      6'h24
`define CPU_FN_OR       6'h25
`define CPU_FN_SLT      6'h2A

`endif

/* logic/cpu_pkg.sv */
// Pipeline CPU types
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_idx_t;

    // the two ways one instruction word is read
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_instr_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm16;
    } i_instr_t;

    typedef union packed {
        r_instr_t r_view;
        i_instr_t i_view;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    //*******************************************************************
    // stage registers
    //*******************************************************************
    typedef struct packed {
        logic   valid;
        word_t  pc_plus4;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc_plus4;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm;
        reg_idx_t dest;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     alu_src_imm;
        logic     branch;
        logic     halt;
        alu_op_t  alu_op;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_out;
        word_t    store_data;
        reg_idx_t dest;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch_taken;
        word_t    branch_target;
        logic     halt;
    } ex_mem_t;

    // also the forwarding and register write bundle
    typedef struct packed {
        logic     valid;
        word_t    wdat;
        reg_idx_t dest;
        logic     reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module fetch_stage (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             stall,
    input  logic             redirect,
    input  cpu_pkg::word_t   redirect_pc,
    input  logic             halt,
    input  cpu_pkg::word_t   imem_load,
    output cpu_pkg::word_t   imem_addr,
    output cpu_pkg::if_id_t  if_id
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus4;

    assign pc_plus4  = pc + word_t'(4);
    assign imem_addr = pc;

    // program counter frozen by halt
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            pc <= `CPU_PC_INIT;
        end
        else if (!halt)
        begin
            if (redirect)
            begin
                pc <= redirect_pc;
            end
            else if (!stall)
            begin
                pc <= pc_plus4;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            if_id <= '0;
        end
        else if (!halt)
        begin
            if (redirect)
            begin
                if_id.valid <= 1'b0;
            end
            else if (!stall)
            begin
                if_id.valid    <= 1'b1;
                if_id.pc_plus4 <= pc_plus4;
                if_id.instr    <= instr_u'(imem_load);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module decode_stage (
    input  logic             CLK,
    input  logic             nRST,
    input  cpu_pkg::if_id_t  if_id,
    input  cpu_pkg::mem_wb_t mem_wb,
    input  logic             redirect,
    input  logic             halt,
    output cpu_pkg::id_ex_t  id_ex,
    output logic             stall
);
    import cpu_pkg::*;

    instr_u  instr;
    id_ex_t  id_ex_d;
    logic    uses_rs;
    logic    uses_rt;
    logic    wr_en;
    word_t   regs [0:`CPU_NREGS-1];

    assign instr = if_id.instr;

    //*******************************************************************
    // register file
    //*******************************************************************
    // r0 is never written
    assign wr_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.dest != '0);

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            for (int i = 0; i < `CPU_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[mem_wb.dest] <= mem_wb.wdat;
        end
    end

    //*******************************************************************
    // control decode
    //*******************************************************************
    always_comb
    begin
        id_ex_d          = '0;
        id_ex_d.valid    = if_id.valid;
        id_ex_d.pc_plus4 = if_id.pc_plus4;
        id_ex_d.rs       = instr.r_view.rs;
        id_ex_d.rt       = instr.r_view.rt;
        id_ex_d.imm      = {{(`CPU_WORD_W-16){instr.i_view.imm16[15]}}, instr.i_view.imm16};
        id_ex_d.dest     = instr.i_view.rt;
        id_ex_d.alu_op   = ALU_ADD;
        uses_rs          = 1'b0;
        uses_rt          = 1'b0;

        // same-cycle write-back bypass
        id_ex_d.rdat1 = (wr_en && mem_wb.dest == id_ex_d.rs) ? mem_wb.wdat : regs[id_ex_d.rs];
        id_ex_d.rdat2 = (wr_en && mem_wb.dest == id_ex_d.rt) ? mem_wb.wdat : regs[id_ex_d.rt];

        case (instr.r_view.opcode)
            `CPU_OP_RTYPE:
            begin
                uses_rs           = 1'b1;
                uses_rt           = 1'b1;
                id_ex_d.dest      = instr.r_view.rd;
                id_ex_d.reg_write = 1'b1;
                case (instr.r_view.funct)
                    `CPU_FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    `CPU_FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    `CPU_FN_AND:  id_ex_d.alu_op = ALU_AND;
                    `CPU_FN_OR:   id_ex_d.alu_op = ALU_OR;
                    `CPU_FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    // unknown funct acts as a nop
                    default:      id_ex_d.reg_write = 1'b0;
                endcase
            end
            `CPU_OP_ADDIU, `CPU_OP_LW:
            begin
                uses_rs             = 1'b1;
                id_ex_d.reg_write   = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
                id_ex_d.mem_read    = (instr.i_view.opcode == `CPU_OP_LW);
            end
            `CPU_OP_SW:
            begin
                uses_rs             = 1'b1;
                uses_rt             = 1'b1;
                id_ex_d.mem_write   = 1'b1;
                id_ex_d.alu_src_imm = 1'b1;
            end
            `CPU_OP_BEQ:
            begin
                uses_rs        = 1'b1;
                uses_rt        = 1'b1;
                id_ex_d.branch = 1'b1;
                id_ex_d.alu_op = ALU_SUB;
            end
            `CPU_OP_HALT: id_ex_d.halt = 1'b1;
            default:      ;
        endcase
    end

    // load-use hazard against the load now in ID/EX
    assign stall = if_id.valid && id_ex.valid && id_ex.mem_read && (id_ex.dest != '0) &&
                   ((uses_rs && id_ex.dest == id_ex_d.rs) ||
                    (uses_rt && id_ex.dest == id_ex_d.rt));

    // ID/EX register takes a bubble on stall or flush
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            id_ex <= '0;
        end
        else if (!halt)
        begin
            if (redirect || stall)
            begin
                id_ex <= '0;
            end
            else
            begin
                id_ex <= id_ex_d;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// Execute stage
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic             CLK,
    input  logic             nRST,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::ex_mem_t ex_mem_fwd,
    input  cpu_pkg::mem_wb_t mem_wb,
    input  logic             redirect,
    input  logic             halt,
    output cpu_pkg::ex_mem_t ex_mem
);
    import cpu_pkg::*;

    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_out;
    ex_mem_t ex_mem_d;

    // EX/MEM result beats MEM/WB; loads in EX/MEM are covered by the stall
    function automatic word_t fwd_sel(input reg_idx_t src, input word_t rdat,
                                      input ex_mem_t em, input mem_wb_t mw);
        word_t sel;
        if (src != '0 && em.valid && em.reg_write && !em.mem_read && em.dest == src)
        begin
            sel = em.alu_out;
        end
        else if (src != '0 && mw.valid && mw.reg_write && mw.dest == src)
        begin
            sel = mw.wdat;
        end
        else
        begin
            sel = rdat;
        end
        return sel;
    endfunction

    assign op_a  = fwd_sel(id_ex.rs, id_ex.rdat1, ex_mem_fwd, mem_wb);
    assign op_b  = fwd_sel(id_ex.rt, id_ex.rdat2, ex_mem_fwd, mem_wb);
    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : op_b;

    //*******************************************************************
    // ALU
    //*******************************************************************
    always_comb
    begin
        case (id_ex.alu_op)
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_SLT: alu_out = {{(`CPU_WORD_W-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_out = op_a + alu_b;
        endcase
    end

    always_comb
    begin
        ex_mem_d.valid         = id_ex.valid;
        ex_mem_d.alu_out       = alu_out;
        ex_mem_d.store_data    = op_b;
        ex_mem_d.dest          = id_ex.dest;
        ex_mem_d.reg_write     = id_ex.reg_write;
        ex_mem_d.mem_read      = id_ex.mem_read;
        ex_mem_d.mem_write     = id_ex.mem_write;
        ex_mem_d.halt          = id_ex.halt;
        // BEQ compare and target
        ex_mem_d.branch_taken  = id_ex.valid && id_ex.branch && (op_a == op_b);
        ex_mem_d.branch_target = id_ex.pc_plus4 + {id_ex.imm[`CPU_WORD_W-3:0], 2'b00};
    end

    // EX/MEM register
    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            ex_mem <= '0;
        end
        else if (!halt)
        begin
            if (redirect)
            begin
                ex_mem <= '0;
            end
            else
            begin
                ex_mem <= ex_mem_d;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
// Memory access stage
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic             CLK,
    input  logic             nRST,
    input  cpu_pkg::ex_mem_t ex_mem,
    input  cpu_pkg::word_t   dmem_load,
    output cpu_pkg::word_t   dmem_addr,
    output cpu_pkg::word_t   dmem_store,
    output logic             dmem_wen,
    output logic             dmem_ren,
    output logic             redirect,
    output cpu_pkg::word_t   redirect_pc,
    output logic             halt,
    output cpu_pkg::mem_wb_t mem_wb
);
    import cpu_pkg::*;

    logic halt_q;

    assign dmem_addr  = ex_mem.alu_out;
    assign dmem_store = ex_mem.store_data;
    assign dmem_wen   = ex_mem.valid && ex_mem.mem_write && !halt_q;
    assign dmem_ren   = ex_mem.valid && ex_mem.mem_read && !halt_q;

    // taken branch flushes the three younger stages
    assign redirect    = ex_mem.valid && ex_mem.branch_taken;
    assign redirect_pc = ex_mem.branch_target;

    // high from the first cycle HALT is here until reset
    assign halt = halt_q || (ex_mem.valid && ex_mem.halt);

    always_ff @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            halt_q <= 1'b0;
            mem_wb <= '0;
        end
        else
        begin
            halt_q           <= halt;
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.wdat      <= ex_mem.mem_read ? dmem_load : ex_mem.alu_out;
            mem_wb.dest      <= ex_mem.dest;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

endmodule

`default_nettype wire

/* logic/pipeline_cpu.sv */
// Pipelined MIPS subset CPU
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu (
    input  logic           CLK,
    input  logic           nRST,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_load,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_store,
    output logic           dmem_wen,
    output logic           dmem_ren,
    input  cpu_pkg::word_t dmem_load,
    output logic           halt
);
    import cpu_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    stall;
    logic    redirect;
    word_t   redirect_pc;

    fetch_stage fetch_i (
        .CLK(CLK), .nRST(nRST), .stall(stall), .redirect(redirect),
        .redirect_pc(redirect_pc), .halt(halt), .imem_load(imem_load),
        .imem_addr(imem_addr), .if_id(if_id)
    );

    decode_stage decode_i (
        .CLK(CLK), .nRST(nRST), .if_id(if_id), .mem_wb(mem_wb),
        .redirect(redirect), .halt(halt), .id_ex(id_ex), .stall(stall)
    );

    // ex_mem loops back for forwarding
    execute_stage execute_i (
        .CLK(CLK), .nRST(nRST), .id_ex(id_ex), .ex_mem_fwd(ex_mem),
        .mem_wb(mem_wb), .redirect(redirect), .halt(halt), .ex_mem(ex_mem)
    );

    memory_stage memory_i (
        .CLK(CLK), .nRST(nRST), .ex_mem(ex_mem), .dmem_load(dmem_load),
        .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dmem_wen(dmem_wen),
        .dmem_ren(dmem_ren), .redirect(redirect), .redirect_pc(redirect_pc),
        .halt(halt), .mem_wb(mem_wb)
    );

endmodule

`default_nettype wire

/* verif/cpu_checker.sv */
// Reference model and store checker
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_checker #(
    parameter int PROG_LEN = 208
) (
    input  logic           CLK,
    input  logic           nRST,
    input  cpu_pkg::word_t prog [0:PROG_LEN-1],
    input  cpu_pkg::word_t dmem_addr,
    input  cpu_pkg::word_t dmem_store,
    input  logic           dmem_wen,
    input  logic           dmem_ren,
    input  logic           halt,
    input  logic           done,
    output int             err_count,
    output int             store_count,
    output int             model_stores
);
    import cpu_pkg::*;

    localparam int STEP_LIMIT = 8 * PROG_LEN;

    word_t exp_addr [$];
    word_t exp_data [$];
    word_t exp_load [$];
    word_t want_addr;
    word_t want_data;
    word_t want_load;
    logic  halt_seen;
    logic  final_done;
    int    since_rst;
    int    load_count;
    int    model_loads;

    task automatic require_low(input string name, input logic value);
        if (value !== 1'b0)
        begin
            $display("** Error %s: got %h, expected 0 at %0t", name, value, $time);
            err_count++;
        end
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t want);
        if (got !== want)
        begin
            $display("** Error %s: got %h, expected %h at %0t", name, got, want, $time);
            err_count++;
        end
    endtask

    //**********************************************************************
    // sequential ISA model collecting the expected stores and loads
    //**********************************************************************
    task automatic run_model();
        word_t  regs [0:31];
        word_t  mem  [0:63];
        word_t  instr;
        word_t  simm;
        word_t  a;
        word_t  b;
        word_t  ea;
        int     pc;
        int     steps;
        logic   running;
        pc      = 0;
        steps   = 0;
        running = 1'b1;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < 64; i++)
            mem[i] = '0;
        while (running && steps < STEP_LIMIT)
        begin
            instr = (pc < PROG_LEN) ? prog[pc] : '0;
            simm  = {{16{instr[15]}}, instr[15:0]};
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            ea    = a + simm;
            steps++;
            pc++;
            case (instr[31:26])
                `CPU_OP_RTYPE:
                begin
                    // r0 stays zero
                    if (instr[15:11] != 5'd0)
                    begin
                        case (instr[5:0])
                            `CPU_FN_ADDU: regs[instr[15:11]] = a + b;
                            `CPU_FN_SUBU: regs[instr[15:11]] = a - b;
                            `CPU_FN_AND:  regs[instr[15:11]] = a & b;
                            `CPU_FN_OR:   regs[instr[15:11]] = a | b;
                            `CPU_FN_SLT:  regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                            default:      ;
                        endcase
                    end
                end
                `CPU_OP_ADDIU:
                begin
                    if (instr[20:16] != 5'd0)
                        regs[instr[20:16]] = ea;
                end
                `CPU_OP_LW:
                begin
                    exp_load.push_back(ea);
                    model_loads++;
                    if (instr[20:16] != 5'd0)
                        regs[instr[20:16]] = mem[ea[7:2]];
                end
                `CPU_OP_SW:
                begin
                    mem[ea[7:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                    model_stores++;
                end
                `CPU_OP_BEQ:
                begin
                    if (a == b)
                        pc = pc + int'($signed(simm));
                end
                `CPU_OP_HALT: running = 1'b0;
                default:      ;
            endcase
        end
        if (running)
        begin
            $display("model did not reach HALT within %0d steps", STEP_LIMIT);
            err_count++;
        end
    endtask

    initial
    begin
        err_count    = 0;
        store_count  = 0;
        model_stores = 0;
        load_count   = 0;
        model_loads  = 0;
        halt_seen    = 1'b0;
        final_done   = 1'b0;
        since_rst    = 0;
        @(posedge nRST);
        run_model();
    end

    // sampled mid-cycle away from the clock edge
    always @(negedge CLK)
    begin
        if (!nRST || since_rst == 0)
        begin
            require_low("dmem_wen", dmem_wen);
            require_low("dmem_ren", dmem_ren);
            require_low("halt", halt);
        end
        if (nRST && dmem_wen)
        begin
            store_count++;
            if (halt_seen)
            begin
                $display("store seen after halt at %0t", $time);
                err_count++;
            end
            if (exp_addr.size() == 0)
            begin
                $display("DUT store with no matching model store at %0t", $time);
                err_count++;
            end
            else
            begin
                want_addr = exp_addr.pop_front();
                want_data = exp_data.pop_front();
                compare_word("dmem_addr", dmem_addr, want_addr);
                compare_word("dmem_store", dmem_store, want_data);
            end
        end
        if (nRST && dmem_ren)
        begin
            load_count++;
            if (exp_load.size() == 0)
            begin
                $display("DUT load with no matching model load at %0t", $time);
                err_count++;
            end
            else
            begin
                want_load = exp_load.pop_front();
                compare_word("dmem_addr", dmem_addr, want_load);
            end
        end
        if (nRST && halt && !halt_seen)
        begin
            halt_seen = 1'b1;
            if (exp_addr.size() != 0)
            begin
                $display("halt rose with %0d model stores still pending", exp_addr.size());
                err_count++;
            end
        end
        if (done && !final_done)
        begin
            final_done = 1'b1;
            compare_word("store count", word_t'(store_count), word_t'(model_stores));
            compare_word("load count", word_t'(load_count), word_t'(model_loads));
        end
        if (!nRST)
            since_rst = 0;
        else
            since_rst++;
    end

endmodule

`default_nettype wire

/* verif/cpu_tb.sv */
// CPU testbench top
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int BODY_LEN        = 200;
    localparam int PROG_LEN        = BODY_LEN + 8;
    localparam int WATCHDOG_CYCLES = 4 * PROG_LEN + 100;

    logic        CLK;
    logic        nRST;
    logic        done;
    word_t       imem_addr;
    word_t       imem_load;
    word_t       dmem_addr;
    word_t       dmem_store;
    word_t       dmem_load;
    logic        dmem_wen;
    logic        dmem_ren;
    logic        halt;
    int          err_count;
    int          store_count;
    int          model_stores;
    logic [31:0] rng_state;
    word_t       prog [0:PROG_LEN-1];
    word_t       dmem [0:63];

    always #4 CLK = ~CLK;

    pipeline_cpu dut_i (
        .CLK(CLK), .nRST(nRST), .imem_addr(imem_addr), .imem_load(imem_load),
        .dmem_addr(dmem_addr), .dmem_store(dmem_store), .dmem_wen(dmem_wen),
        .dmem_ren(dmem_ren), .dmem_load(dmem_load), .halt(halt)
    );

    cpu_checker #(.PROG_LEN(PROG_LEN)) checker_i (
        .CLK(CLK), .nRST(nRST), .prog(prog), .dmem_addr(dmem_addr),
        .dmem_store(dmem_store), .dmem_wen(dmem_wen), .dmem_ren(dmem_ren),
        .halt(halt), .done(done), .err_count(err_count),
        .store_count(store_count), .model_stores(model_stores)
    );

    //**********************************************************************
    // memory models answering in the same cycle
    //**********************************************************************
    always_comb
    begin
        if (imem_addr < word_t'(4 * PROG_LEN))
            imem_load = prog[imem_addr[9:2]];
        else
            imem_load = '0;
    end

    assign dmem_load = dmem[dmem_addr[7:2]];

    always @(posedge CLK, negedge nRST)
    begin
        if (!nRST)
        begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= '0;
        end
        else if (dmem_wen)
        begin
            dmem[dmem_addr[7:2]] <= dmem_store;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t rtype_word(input logic [5:0] fn, input reg_idx_t rs,
                                         input reg_idx_t rt, input reg_idx_t rd);
        return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // random body on r0..r7 followed by stores of r1..r7 and a halt
    task automatic gen_program();
        word_t      r;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [5:0] fn;
        for (int i = 0; i < BODY_LEN; i++)
        begin
            rng_state = xorshift32(rng_state);
            r  = rng_state;
            rs = {2'b00, r[2:0]};
            rt = {2'b00, r[5:3]};
            rd = {2'b00, r[8:6]};
            case (r[14:12])
                3'd0, 3'd5: fn = `CPU_FN_ADDU;
                3'd1, 3'd6: fn = `CPU_FN_SUBU;
                3'd2, 3'd7: fn = `CPU_FN_AND;
                3'd3:       fn = `CPU_FN_OR;
                default:    fn = `CPU_FN_SLT;
            endcase
            case (r[11:9])
                3'd3, 3'd7: prog[i] = itype_word(`CPU_OP_ADDIU, rs, rt, r[31:16]);
                3'd4:       prog[i] = itype_word(`CPU_OP_LW, 5'd0, rt, {8'd0, r[20:15], 2'b00});
                3'd5:       prog[i] = itype_word(`CPU_OP_SW, 5'd0, rt, {8'd0, r[20:15], 2'b00});
                // forward branch skipping 1 to 4 instructions
                3'd6:       prog[i] = itype_word(`CPU_OP_BEQ, rs, rt, 16'(r[22:21]) + 16'd1);
                default:    prog[i] = rtype_word(fn, rs, rt, rd);
            endcase
        end
        for (int k = 1; k <= 7; k++)
        begin
            prog[BODY_LEN + k - 1] = itype_word(`CPU_OP_SW, 5'd0, 5'(k), 16'(4 * k));
        end
        prog[PROG_LEN - 1] = {`CPU_OP_HALT, 26'd0};
    endtask

    task automatic print_summary();
        $display("errors: %0d, stores: %0d, model stores: %0d",
                 err_count, store_count, model_stores);
    endtask

    initial
    begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        done      = 1'b0;
        rng_state = 32'd75842;
        gen_program();
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        while (!halt)
            @(negedge CLK);
        // a few more cycles to catch any late store
        repeat (10) @(negedge CLK);
        @(posedge CLK);
        done <= 1'b1;
        repeat (2) @(negedge CLK);
        print_summary();
        if (err_count == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: halt was not reached within %0d cycles", WATCHDOG_CYCLES);
        print_summary();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pipeline_cpu.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
